// File: design/i3c_target_pkg.sv
// ================================================
// I3C target data path package
// Transfer types, flow states and CSR map
// ================================================

`default_nettype none

package i3c_target_pkg;

  // Transfer type reported by the frame parser with each start pulse
  typedef enum logic [1:0] {
    XferWrite    = 2'b00,
    XferRead     = 2'b01,
    XferCcc      = 2'b10,
    XferReserved = 2'b11
  } transfer_type_e;

  // Flow controller states
  typedef enum logic [2:0] {
    Idle          = 3'd0,
    TransferWait  = 3'd1,
    TransferWrite = 3'd2,
    TransferRead  = 3'd3,
    TransferCcc   = 3'd4,
    TransferDrop  = 3'd5
  } flow_state_e;

  // Register map of the CSR block
  typedef enum logic [2:0] {
    CsrCtrl    = 3'd0,
    CsrStatus  = 3'd1,
    CsrRxCount = 3'd2,
    CsrTxCount = 3'd3
  } csr_addr_e;

  // CsrCtrl fields
  localparam int CtrlEnableBit = 0;
  // Forward CCC bytes into the RX queue when set
  localparam int CtrlCccFwdBit = 1;

  // CsrStatus fields, write one to clear
  localparam int StatBadTypeBit   = 0;
  // Read started while the TX queue was empty
  localparam int StatReadEmptyBit = 1;

endpackage : i3c_target_pkg

`default_nettype wire

// File: design/tti_queue.sv
// ================================================
// TTI byte queue
// First-word-fall-through FIFO, credit on each pop
// ================================================

`timescale 1ns/1ps
`default_nettype none

module tti_queue #(
  parameter int unsigned Depth = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Write side, producer holds credits
  input  logic       push_i,
  input  logic [7:0] push_data_i,
  // Read side, head entry shown directly
  input  logic       pop_i,
  output logic       valid_o,
  output logic [7:0] data_o,
  // One pulse per popped entry
  output logic       credit_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [7:0]      mem_q [Depth];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] count_q;
  logic            full;
  logic            do_push;
  logic            do_pop;
  logic            credit_q;

  assign full    = (count_q == CntW'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Protect storage even if a producer misbehaves
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && valid_o;

  // Storage array, no reset needed
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ptr
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_count
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Credit goes back one cycle after the entry leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_credit
    if (!rst_ni) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= do_pop;
    end
  end

  assign credit_o = credit_q;

  // Producer must never spend a credit it does not have
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full);

  // Consumer only pops a valid head
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> valid_o);

endmodule : tti_queue

`default_nettype wire

// File: design/flow_standby.sv
// ================================================
// Transfer flow controller
// Moves bus bytes between framing and TTI queues
// ================================================

`timescale 1ns/1ps
`default_nettype none

module flow_standby #(
  parameter int unsigned RxDepth = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Control from the CSR block
  input  logic                           enable_i,
  input  logic                           ccc_fwd_i,
  // Framing from the parser
  input  logic                           transfer_start_i,
  input  logic                           transfer_stop_i,
  input  i3c_target_pkg::transfer_type_e transfer_type_i,
  // Bus receive byte stream
  input  logic                           rx_byte_valid_i,
  input  logic [7:0]                     rx_byte_i,
  output logic                           rx_byte_ready_o,
  // Bus transmit byte stream
  output logic                           tx_byte_valid_o,
  output logic [7:0]                     tx_byte_o,
  input  logic                           tx_byte_ready_i,
  // Credit based RX queue push
  output logic                           rxq_push_o,
  output logic [7:0]                     rxq_data_o,
  input  logic                           rxq_credit_i,
  // TX queue head
  input  logic                           txq_valid_i,
  input  logic [7:0]                     txq_data_i,
  output logic                           txq_pop_o,
  // Event pulses to the CSR block
  output logic                           ev_rx_byte_o,
  output logic                           ev_tx_byte_o,
  output logic                           ev_bad_type_o,
  output logic                           ev_read_empty_o
);

  import i3c_target_pkg::*;

  localparam int unsigned CrW = $clog2(RxDepth + 1);

  flow_state_e    state_q, state_d;
  logic [CrW-1:0] credit_q;
  logic           hold_valid_q;
  logic [7:0]     hold_data_q;
  logic           push_q;
  logic [7:0]     push_data_q;
  logic           start_seen;
  logic           rx_state;
  logic           hold_move;
  logic           rx_take;

  // Start only counts while waiting and enabled
  assign start_seen = (state_q == TransferWait) && enable_i && transfer_start_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (enable_i) begin
          state_d = TransferWait;
        end
      end
      TransferWait: begin
        if (!enable_i) begin
          state_d = Idle;
        end else if (transfer_start_i) begin
          unique case (transfer_type_i)
            XferWrite: state_d = TransferWrite;
            XferRead:  state_d = TransferRead;
            XferCcc:   state_d = ccc_fwd_i ? TransferCcc : TransferDrop;
            default:   state_d = TransferDrop;
          endcase
        end
      end
      TransferWrite, TransferRead, TransferCcc, TransferDrop: begin
        // Disable only takes effect at the end of a transfer
        if (transfer_stop_i) begin
          state_d = enable_i ? TransferWait : Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Bytes go from the bus through the hold register and push stage into the queue
  assign rx_state  = (state_q == TransferWrite) || (state_q == TransferCcc);
  assign hold_move = hold_valid_q && (credit_q != '0);

  // Drop state swallows bytes while rx states need room in the hold register
  assign rx_byte_ready_o = (state_q == TransferDrop) ||
                           (rx_state && (!hold_valid_q || hold_move));
  assign rx_take = rx_state && rx_byte_valid_i && rx_byte_ready_o;

  // Hold register drains on its own even after the transfer ended
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_hold
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
      push_q       <= 1'b0;
    end else begin
      if (rx_take) begin
        hold_valid_q <= 1'b1;
      end else if (hold_move) begin
        hold_valid_q <= 1'b0;
      end
      push_q <= hold_move;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_take) begin
      hold_data_q <= rx_byte_i;
    end
    if (hold_move) begin
      push_data_q <= hold_data_q;
    end
  end

  // One credit is spent per push and one returned per queue pop
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_credit
    if (!rst_ni) begin
      credit_q <= CrW'(RxDepth);
    end else begin
      credit_q <= credit_q - CrW'(hold_move) + CrW'(rxq_credit_i);
    end
  end

  assign rxq_push_o = push_q;
  assign rxq_data_o = push_data_q;

  // Head of the TX queue goes straight to the bus
  assign tx_byte_valid_o = (state_q == TransferRead) && txq_valid_i;
  assign tx_byte_o       = txq_data_i;
  assign txq_pop_o       = tx_byte_valid_o && tx_byte_ready_i;

  // Events
  assign ev_rx_byte_o    = push_q;
  assign ev_tx_byte_o    = txq_pop_o;
  assign ev_bad_type_o   = start_seen && (transfer_type_i == XferReserved);
  assign ev_read_empty_o = start_seen && (transfer_type_i == XferRead) && !txq_valid_i;

  // A push in flight keeps its credit out of the pool
  a_push_has_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rxq_push_o |-> (credit_q < CrW'(RxDepth)));

  // Queue never returns more credits than it was given
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CrW'(RxDepth));

endmodule : flow_standby

`default_nettype wire

// File: design/target_csr.sv
// ================================================
// Target control and status registers
// Enable, CCC forwarding, sticky errors, counters
// ================================================

`timescale 1ns/1ps
`default_nettype none

module target_csr #(
  parameter int unsigned CntWidth = 16
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Software register port
  input  logic                      reg_we_i,
  input  i3c_target_pkg::csr_addr_e reg_addr_i,
  input  logic [31:0]               reg_wdata_i,
  output logic [31:0]               reg_rdata_o,
  // Events from the flow controller
  input  logic                      ev_rx_byte_i,
  input  logic                      ev_tx_byte_i,
  input  logic                      ev_bad_type_i,
  input  logic                      ev_read_empty_i,
  // Control outputs
  output logic                      enable_o,
  output logic                      ccc_fwd_o
);

  import i3c_target_pkg::*;

  logic                ctrl_enable_q;
  logic                ctrl_ccc_fwd_q;
  logic                stat_bad_type_q;
  logic                stat_read_empty_q;
  logic [CntWidth-1:0] rx_cnt_q;
  logic [CntWidth-1:0] tx_cnt_q;
  logic                wr_ctrl;
  logic                wr_status;
  logic                wr_rx_cnt;
  logic                wr_tx_cnt;

  // Address decode
  assign wr_ctrl   = reg_we_i && (reg_addr_i == CsrCtrl);
  assign wr_status = reg_we_i && (reg_addr_i == CsrStatus);
  assign wr_rx_cnt = reg_we_i && (reg_addr_i == CsrRxCount);
  assign wr_tx_cnt = reg_we_i && (reg_addr_i == CsrTxCount);

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl
    if (!rst_ni) begin
      ctrl_enable_q  <= 1'b0;
      ctrl_ccc_fwd_q <= 1'b0;
    end else if (wr_ctrl) begin
      ctrl_enable_q  <= reg_wdata_i[CtrlEnableBit];
      ctrl_ccc_fwd_q <= reg_wdata_i[CtrlCccFwdBit];
    end
  end

  // Sticky flags, W1C; a new event beats a clear
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_status
    if (!rst_ni) begin
      stat_bad_type_q   <= 1'b0;
      stat_read_empty_q <= 1'b0;
    end else begin
      stat_bad_type_q   <= ev_bad_type_i |
                           (stat_bad_type_q & ~(wr_status & reg_wdata_i[StatBadTypeBit]));
      stat_read_empty_q <= ev_read_empty_i |
                           (stat_read_empty_q & ~(wr_status & reg_wdata_i[StatReadEmptyBit]));
    end
  end

  // Wrapping counters; any write clears, a same-cycle event still counts
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_counters
    if (!rst_ni) begin
      rx_cnt_q <= '0;
      tx_cnt_q <= '0;
    end else begin
      if (wr_rx_cnt) begin
        rx_cnt_q <= CntWidth'(ev_rx_byte_i);
      end else if (ev_rx_byte_i) begin
        rx_cnt_q <= rx_cnt_q + 1'b1;
      end
      if (wr_tx_cnt) begin
        tx_cnt_q <= CntWidth'(ev_tx_byte_i);
      end else if (ev_tx_byte_i) begin
        tx_cnt_q <= tx_cnt_q + 1'b1;
      end
    end
  end

  // Combinational read mux, unknown addresses read zero
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      CsrCtrl: begin
        reg_rdata_o[CtrlEnableBit] = ctrl_enable_q;
        reg_rdata_o[CtrlCccFwdBit] = ctrl_ccc_fwd_q;
      end
      CsrStatus: begin
        reg_rdata_o[StatBadTypeBit]   = stat_bad_type_q;
        reg_rdata_o[StatReadEmptyBit] = stat_read_empty_q;
      end
      CsrRxCount: reg_rdata_o = 32'(rx_cnt_q);
      CsrTxCount: reg_rdata_o = 32'(tx_cnt_q);
      default:    reg_rdata_o = '0;
    endcase
  end

  assign enable_o  = ctrl_enable_q;
  assign ccc_fwd_o = ctrl_ccc_fwd_q;

  // Software only writes mapped registers
  a_known_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_we_i |-> (reg_addr_i inside {CsrCtrl, CsrStatus, CsrRxCount, CsrTxCount}));

endmodule : target_csr

`default_nettype wire

// File: design/i3c_target_top.sv
// ================================================
// I3C target byte data path top level
// Flow controller, RX/TX queues and CSR block
// ================================================

`timescale 1ns/1ps
`default_nettype none

module i3c_target_top #(
  parameter int unsigned RxDepth  = 8,
  parameter int unsigned TxDepth  = 4,
  parameter int unsigned CntWidth = 16
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Bus receive bytes
  input  logic                           rx_byte_valid_i,
  input  logic [7:0]                     rx_byte_i,
  output logic                           rx_byte_ready_o,
  // Bus transmit bytes
  output logic                           tx_byte_valid_o,
  output logic [7:0]                     tx_byte_o,
  input  logic                           tx_byte_ready_i,
  // Framing
  input  logic                           transfer_start_i,
  input  logic                           transfer_stop_i,
  input  i3c_target_pkg::transfer_type_e transfer_type_i,
  // Host RX drain
  output logic                           rx_valid_o,
  output logic [7:0]                     rx_data_o,
  input  logic                           rx_pop_i,
  // Host TX fill, credit based
  input  logic                           tx_push_i,
  input  logic [7:0]                     tx_data_i,
  output logic                           tx_credit_o,
  // Register port
  input  logic                           reg_we_i,
  input  i3c_target_pkg::csr_addr_e      reg_addr_i,
  input  logic [31:0]                    reg_wdata_i,
  output logic [31:0]                    reg_rdata_o
);

  // Flow controller to queues
  logic       rxq_push;
  logic [7:0] rxq_data;
  logic       rxq_credit;
  logic       txq_valid;
  logic [7:0] txq_data;
  logic       txq_pop;

  // Events and control between flow and CSR
  logic       ev_rx_byte;
  logic       ev_tx_byte;
  logic       ev_bad_type;
  logic       ev_read_empty;
  logic       ctrl_enable;
  logic       ctrl_ccc_fwd;

  flow_standby #(
    .RxDepth(RxDepth)
  ) u_flow (
    .clk_i, .rst_ni,
    .enable_i(ctrl_enable), .ccc_fwd_i(ctrl_ccc_fwd),
    .transfer_start_i, .transfer_stop_i, .transfer_type_i,
    .rx_byte_valid_i, .rx_byte_i, .rx_byte_ready_o,
    .tx_byte_valid_o, .tx_byte_o, .tx_byte_ready_i,
    .rxq_push_o(rxq_push), .rxq_data_o(rxq_data), .rxq_credit_i(rxq_credit),
    .txq_valid_i(txq_valid), .txq_data_i(txq_data), .txq_pop_o(txq_pop),
    .ev_rx_byte_o(ev_rx_byte), .ev_tx_byte_o(ev_tx_byte),
    .ev_bad_type_o(ev_bad_type), .ev_read_empty_o(ev_read_empty)
  );

  // RX queue, flow controller is the credited producer
  tti_queue #(.Depth(RxDepth)) u_rx_queue (
    .clk_i, .rst_ni,
    .push_i(rxq_push), .push_data_i(rxq_data),
    .pop_i(rx_pop_i), .valid_o(rx_valid_o), .data_o(rx_data_o),
    .credit_o(rxq_credit)
  );

  // TX queue, host is the credited producer
  tti_queue #(.Depth(TxDepth)) u_tx_queue (
    .clk_i, .rst_ni,
    .push_i(tx_push_i), .push_data_i(tx_data_i),
    .pop_i(txq_pop), .valid_o(txq_valid), .data_o(txq_data),
    .credit_o(tx_credit_o)
  );

  target_csr #(.CntWidth(CntWidth)) u_csr (
    .clk_i, .rst_ni,
    .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .ev_rx_byte_i(ev_rx_byte), .ev_tx_byte_i(ev_tx_byte),
    .ev_bad_type_i(ev_bad_type), .ev_read_empty_i(ev_read_empty),
    .enable_o(ctrl_enable), .ccc_fwd_o(ctrl_ccc_fwd)
  );

endmodule : i3c_target_top

`default_nettype wire

// File: verification/tb_i3c_target.sv
// ================================================
// Testbench for the I3C target byte data path
// Scoreboards and assertions on RX, TX and CSRs
// ================================================

`timescale 1ns/1ps
`default_nettype none

module tb_i3c_target;

  import i3c_target_pkg::*;

  localparam int RxDepth  = 8;
  localparam int TxDepth  = 4;
  localparam int MaxCycle = 4000;

  logic           clk_i;
  logic           rst_ni;
  logic           rx_byte_valid_i;
  logic [7:0]     rx_byte_i;
  logic           rx_byte_ready_o;
  logic           tx_byte_valid_o;
  logic [7:0]     tx_byte_o;
  logic           tx_byte_ready_i;
  logic           transfer_start_i;
  logic           transfer_stop_i;
  transfer_type_e transfer_type_i;
  logic           rx_valid_o;
  logic [7:0]     rx_data_o;
  logic           rx_pop_i;
  logic           tx_push_i;
  logic [7:0]     tx_data_i;
  logic           tx_credit_o;
  logic           reg_we_i;
  csr_addr_e      reg_addr_i;
  logic [31:0]    reg_wdata_i;
  logic [31:0]    reg_rdata_o;

  // Scoreboards and test control
  logic [7:0]  exp_rx[$];
  logic [7:0]  exp_tx[$];
  logic [31:0] rng_rx = 32'd53980;
  logic [31:0] rng_tx = 32'd53980 ^ 32'h5a5a_0f0f;
  logic        drain_en = 1'b0;
  logic        rx_expect = 1'b0;
  logic        lat_chk = 1'b0;
  logic        dis_chk = 1'b0;
  logic        stall_en = 1'b0;
  int          host_credits = TxDepth;
  int          tx_left = 0;
  int          acc_cnt = 0;
  int          cycles = 0;

  i3c_target_top #(.RxDepth(RxDepth), .TxDepth(TxDepth), .CntWidth(16)) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  // Watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycle) begin
      fail_now($sformatf("timeout: run did not finish within %0d cycles", MaxCycle));
    end
  end

  // Host drains the RX queue whenever allowed
  always @(posedge clk_i) begin
    #1;
    rx_pop_i = drain_en && rx_valid_o;
  end

  // Host fills the TX queue under its own credit count
  always @(posedge clk_i) begin
    if (tx_credit_o) begin
      host_credits++;
    end
    #1;
    if (tx_left > 0 && host_credits > 0) begin
      rng_tx = xorshift(rng_tx);
      tx_push_i = 1'b1;
      tx_data_i = rng_tx[7:0];
      exp_tx.push_back(rng_tx[7:0]);
      host_credits--;
      tx_left--;
    end else begin
      tx_push_i = 1'b0;
    end
    tx_byte_ready_i = stall_en ? rng_tx[12] : 1'b1;
    rng_tx = xorshift(rng_tx);
    if (host_credits > TxDepth) begin
      fail_now($sformatf("host credit count out of range: %0d", host_credits));
    end
  end

  // Scoreboard monitor sampled on the rising edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Every byte at the head was accepted earlier with rx_expect set
      if (rx_valid_o && exp_rx.size() == 0) begin
        fail_now("RX queue holds data that should have been dropped");
      end
      if (rx_valid_o && rx_pop_i) begin
        check_eq("rx_data_o", rx_data_o, exp_rx.pop_front());
      end
      if (rx_byte_valid_i && rx_byte_ready_o) begin
        acc_cnt++;
        if (rx_expect) begin
          exp_rx.push_back(rx_byte_i);
        end
      end
      if (tx_byte_valid_o && tx_byte_ready_i) begin
        if (exp_tx.size() == 0) begin
          fail_now("bus read a byte the host never pushed");
        end
        check_eq("tx_byte_o", tx_byte_o, exp_tx.pop_front());
      end
    end
  end

  // Two cycle write latency while the queue drains
  // Head is visible after the second edge and sampled on the third
  a_rx_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lat_chk && rx_byte_valid_i && rx_byte_ready_o) |->
      ##3 (rx_valid_o && rx_data_o == $past(rx_byte_i, 3)))
    else fail_now($sformatf("mismatch at %0t: RX byte not at head two cycles later", $time));

  a_credit_after_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tx_byte_valid_o && tx_byte_ready_i) |=> tx_credit_o)
    else fail_now($sformatf("mismatch at %0t: tx_credit_o missing after pop", $time));

  a_credit_has_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_credit_o |-> $past(tx_byte_valid_o && tx_byte_ready_i))
    else fail_now($sformatf("mismatch at %0t: tx_credit_o without a pop", $time));

  // Stalled head byte holds still
  a_tx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tx_byte_valid_o && !tx_byte_ready_i) |=> (tx_byte_valid_o && $stable(tx_byte_o)))
    else fail_now($sformatf("mismatch at %0t: TX head changed under stall", $time));

  a_disabled_no_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dis_chk |-> !rx_byte_ready_o)
    else fail_now($sformatf("mismatch at %0t: rx_byte_ready_o high while disabled", $time));

  // All tasks start and end 1 ns after a rising edge
  task automatic reg_write(input csr_addr_e a, input logic [31:0] d);
    reg_we_i = 1'b1;
    reg_addr_i = a;
    reg_wdata_i = d;
    @(posedge clk_i);
    #1;
    reg_we_i = 1'b0;
  endtask

  task automatic reg_check(input csr_addr_e a, input logic [31:0] exp);
    reg_addr_i = a;
    @(posedge clk_i);
    check_eq(a.name(), reg_rdata_o, exp);
    #1;
  endtask

  task automatic frame_pulse(input logic is_start, input transfer_type_e t);
    transfer_start_i = is_start;
    transfer_stop_i = !is_start;
    transfer_type_i = t;
    @(posedge clk_i);
    #1;
    transfer_start_i = 1'b0;
    transfer_stop_i = 1'b0;
  endtask

  task automatic bus_byte(input int max_wait, output bit taken);
    int waited;
    taken = 1'b0;
    waited = 0;
    if (!rx_byte_valid_i) begin
      rng_rx = xorshift(rng_rx);
      rx_byte_i = rng_rx[7:0];
    end
    rx_byte_valid_i = 1'b1;
    while (!taken && waited < max_wait) begin
      @(posedge clk_i);
      taken = rx_byte_ready_o;
      waited++;
    end
    #1;
    if (taken) begin
      rx_byte_valid_i = 1'b0;
      // Occasional idle gap on the bus
      if (rng_rx[9]) begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  task automatic send_bytes(input int n);
    bit taken;
    for (int i = 0; i < n; i++) begin
      bus_byte(MaxCycle, taken);
    end
  endtask

  task automatic wait_rx_drained();
    while (exp_rx.size() != 0) begin
      @(posedge clk_i);
    end
    #1;
  endtask

  initial begin
    bit taken;
    rst_ni = 1'b0;
    rx_byte_valid_i = 1'b0;
    rx_byte_i = '0;
    tx_byte_ready_i = 1'b1;
    transfer_start_i = 1'b0;
    transfer_stop_i = 1'b0;
    transfer_type_i = XferWrite;
    rx_pop_i = 1'b0;
    tx_push_i = 1'b0;
    tx_data_i = '0;
    reg_we_i = 1'b0;
    reg_addr_i = CsrCtrl;
    reg_wdata_i = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_eq("reset outputs",
             {rx_byte_ready_o, tx_byte_valid_o, rx_valid_o, tx_credit_o}, 0);
    reg_check(CsrCtrl, 0);
    reg_check(CsrStatus, 0);

    // Write transfer with the host draining
    reg_write(CsrCtrl, 32'h1 << CtrlEnableBit);
    // FSM leaves Idle one cycle after the enable
    @(posedge clk_i);
    #1;
    drain_en = 1'b1;
    rx_expect = 1'b1;
    lat_chk = 1'b1;
    frame_pulse(1'b1, XferWrite);
    send_bytes(12);
    frame_pulse(1'b0, XferWrite);
    wait_rx_drained();
    lat_chk = 1'b0;
    reg_check(CsrRxCount, 12);

    // Back-pressure until the queue and hold register are full
    reg_write(CsrRxCount, 0);
    drain_en = 1'b0;
    acc_cnt = 0;
    frame_pulse(1'b1, XferWrite);
    taken = 1'b1;
    while (taken) begin
      bus_byte(20, taken);
    end
    check_eq("bytes accepted before stall", acc_cnt, RxDepth + 1);
    drain_en = 1'b1;
    bus_byte(MaxCycle, taken);
    send_bytes(2);
    frame_pulse(1'b0, XferWrite);
    wait_rx_drained();
    reg_check(CsrRxCount, RxDepth + 4);

    // Read transfer under random stalls
    tx_left = 10;
    while (exp_tx.size() == 0) begin
      @(posedge clk_i);
    end
    #1;
    stall_en = 1'b1;
    frame_pulse(1'b1, XferRead);
    while (tx_left > 0 || exp_tx.size() != 0) begin
      @(posedge clk_i);
    end
    #1;
    stall_en = 1'b0;
    frame_pulse(1'b0, XferRead);
    while (host_credits != TxDepth) begin
      @(posedge clk_i);
    end
    #1;
    reg_check(CsrTxCount, 10);
    reg_check(CsrStatus, 0);

    // CCC bytes dropped and then forwarded
    reg_write(CsrRxCount, 0);
    rx_expect = 1'b0;
    frame_pulse(1'b1, XferCcc);
    send_bytes(5);
    frame_pulse(1'b0, XferCcc);
    reg_write(CsrCtrl, (32'h1 << CtrlEnableBit) | (32'h1 << CtrlCccFwdBit));
    rx_expect = 1'b1;
    frame_pulse(1'b1, XferCcc);
    send_bytes(6);
    frame_pulse(1'b0, XferCcc);
    wait_rx_drained();
    reg_check(CsrRxCount, 6);

    // Reserved type and read from an empty TX queue
    rx_expect = 1'b0;
    frame_pulse(1'b1, XferReserved);
    send_bytes(3);
    frame_pulse(1'b0, XferReserved);
    reg_check(CsrStatus, 32'h1 << StatBadTypeBit);
    frame_pulse(1'b1, XferRead);
    frame_pulse(1'b0, XferRead);
    reg_check(CsrStatus, (32'h1 << StatBadTypeBit) | (32'h1 << StatReadEmptyBit));
    reg_write(CsrStatus, (32'h1 << StatBadTypeBit) | (32'h1 << StatReadEmptyBit));
    reg_check(CsrStatus, 0);
    reg_check(CsrRxCount, 6);

    // Disabled target ignores a start
    reg_write(CsrCtrl, 0);
    repeat (2) @(posedge clk_i);
    #1;
    dis_chk = 1'b1;
    frame_pulse(1'b1, XferWrite);
    bus_byte(10, taken);
    rx_byte_valid_i = 1'b0;
    dis_chk = 1'b0;
    check_eq("byte taken while disabled", taken, 0);

    $display("=== PASS ===");
    $finish;
  end

endmodule : tb_i3c_target

`default_nettype wire

// File: all.f
design/i3c_target_pkg.sv
design/tti_queue.sv
design/flow_standby.sv
design/target_csr.sv
design/i3c_target_top.sv
verification/tb_i3c_target.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_i3c_target \
		-f all.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
